/* mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// width of every datapath word
`define DATA_W 32

// word address bits, so each memory holds 1024 words
`define IMEM_AW 10
`define DMEM_AW 10

// stores whose address has this top nibble go to the output port
// and never reach the data memory
`define IO_NIBBLE 4'h8

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* isaPkg.sv */
package isaPkg;

	// primary opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LB    = 6'h20,
		OP_LH    = 6'h21,
		OP_LW    = 6'h23,
		OP_LBU   = 6'h24,
		OP_LHU   = 6'h25,
		OP_SB    = 6'h28,
		OP_SH    = 6'h29,
		OP_SW    = 6'h2b
	} opcodeE;

	// function field of R-type words
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_JR   = 6'h08,
		F_JALR = 6'h09,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} functE;

	typedef struct packed {
		opcodeE op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functE funct;
	} rFmtT;

	typedef struct packed {
		opcodeE op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFmtT;

	typedef struct packed {
		opcodeE op;
		logic [25:0] target26;
	} jFmtT;

	// one instruction word, read in whichever format the opcode implies
	typedef union packed {
		rFmtT r;
		iFmtT i;
		jFmtT j;
	} instrU;

endpackage

/* pipePkg.sv */
`include "mips_defs.svh"

package pipePkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} aluOpE;

	typedef enum logic [2:0] {
		SRC_RT,
		SRC_RS,
		SRC_SEXT,
		SRC_ZEXT,
		SRC_ZERO,
		SRC_SHAMT
	} srcBE;

	// stores reuse the word, half and byte kinds together with isStore
	typedef enum logic [2:0] {
		LS_NONE,
		LS_W,
		LS_H,
		LS_HU,
		LS_B,
		LS_BU
	} lsKindE;

	typedef enum logic [1:0] {
		JMP_SEQ,
		JMP_BRANCH,
		JMP_JUMP,
		JMP_REG
	} jumpE;

	typedef struct packed {
		logic regDest;
		logic aluRegSel;
		logic link;
		logic regWrite;
		logic memToReg;
		logic isStore;
		aluOpE aluOp;
		srcBE srcB;
		lsKindE lsKind;
		jumpE jumpKind;
	} ctrlT;

	// fetch to decode/execute
	typedef struct packed {
		logic valid;
		logic [`DATA_W-1:0] pc;
		logic [`DATA_W-1:0] pcPlus4;
	} fetchRegT;

	// execute to writeback
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic link;
		lsKindE lsKind;
		logic [4:0] waddr;
		logic [`DATA_W-1:0] aluOut;
		logic [`DATA_W-1:0] pcPlus8;
	} wbRegT;

endpackage

/* controlUnit.sv */
`timescale 1ns/1ns

module controlUnit (
	input isaPkg::instrU instr,
	output pipePkg::ctrlT ctrl
);
	import isaPkg::*;
	import pipePkg::*;

	always_comb begin
		// anything not listed below stays a bubble
		ctrl = '0;
		case (instr.r.op)
			OP_RTYPE: begin
				ctrl.regDest = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.r.funct)
					F_ADDU: ctrl.aluOp = ALU_ADD;
					F_SUBU: ctrl.aluOp = ALU_SUB;
					F_AND: ctrl.aluOp = ALU_AND;
					F_OR: ctrl.aluOp = ALU_OR;
					F_XOR: ctrl.aluOp = ALU_XOR;
					F_NOR: ctrl.aluOp = ALU_NOR;
					F_SLT: ctrl.aluOp = ALU_SLT;
					F_SLTU: ctrl.aluOp = ALU_SLTU;
					F_SLL, F_SRL, F_SRA: begin
						// shifts move rt by shamt
						ctrl.aluRegSel = 1'b1;
						ctrl.srcB = SRC_SHAMT;
						ctrl.aluOp = (instr.r.funct == F_SLL) ? ALU_SLL :
							(instr.r.funct == F_SRL) ? ALU_SRL : ALU_SRA;
					end
					F_JR, F_JALR: begin
						ctrl.regWrite = (instr.r.funct == F_JALR);
						ctrl.link = 1'b1;
						ctrl.jumpKind = JMP_REG;
						ctrl.aluOp = ALU_OR;
						ctrl.srcB = SRC_RS;
					end
					default: ctrl = '0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				ctrl.regWrite = 1'b1;
				ctrl.srcB = SRC_SEXT;
				ctrl.aluOp = (instr.i.op == OP_ADDIU) ? ALU_ADD :
					(instr.i.op == OP_SLTI) ? ALU_SLT : ALU_SLTU;
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.srcB = SRC_ZEXT;
				ctrl.aluOp = (instr.i.op == OP_ANDI) ? ALU_AND :
					(instr.i.op == OP_ORI) ? ALU_OR :
					(instr.i.op == OP_XORI) ? ALU_XOR : ALU_LUI;
			end
			OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.srcB = SRC_SEXT;
				ctrl.lsKind = (instr.i.op == OP_LW) ? LS_W :
					(instr.i.op == OP_LH) ? LS_H :
					(instr.i.op == OP_LHU) ? LS_HU :
					(instr.i.op == OP_LB) ? LS_B : LS_BU;
			end
			OP_SW, OP_SH, OP_SB: begin
				ctrl.isStore = 1'b1;
				ctrl.srcB = SRC_SEXT;
				ctrl.lsKind = (instr.i.op == OP_SW) ? LS_W :
					(instr.i.op == OP_SH) ? LS_H : LS_B;
			end
			OP_BEQ, OP_BNE: begin
				ctrl.jumpKind = JMP_BRANCH;
				ctrl.aluOp = ALU_SUB;
			end
			OP_J, OP_JAL: begin
				ctrl.jumpKind = JMP_JUMP;
				ctrl.srcB = SRC_ZERO;
				ctrl.link = (instr.j.op == OP_JAL);
				ctrl.regWrite = (instr.j.op == OP_JAL);
			end
			default: ctrl = '0;
		endcase
	end

	// a store must never also claim a register write in writeback
	always_comb begin
		assert final (!(ctrl.regWrite && ctrl.isStore))
			else $error("store decoded with regWrite set");
	end

endmodule

/* alu.sv */
`timescale 1ns/1ns
`include "mips_defs.svh"

module alu (
	input logic [`DATA_W-1:0] a,
	input logic [`DATA_W-1:0] b,
	input pipePkg::aluOpE op,
	output logic [`DATA_W-1:0] result,
	output logic equal
);
	import pipePkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = ($signed(a) < $signed(b)) ? `DATA_W'(1) : '0;
			ALU_SLTU: result = (a < b) ? `DATA_W'(1) : '0;
			// shift amount sits in the low bits of b
			ALU_SLL: result = a << b[4:0];
			ALU_SRL: result = a >> b[4:0];
			ALU_SRA: result = $signed(a) >>> b[4:0];
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	// raw operand compare for beq and bne
	assign equal = (a == b);

endmodule

/* regFile.sv */
`timescale 1ns/1ns
`include "mips_defs.svh"

module regFile (
	input logic clk,
	input logic we,
	input logic [4:0] raddr1,
	input logic [4:0] raddr2,
	input logic [4:0] waddr,
	input logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W-1:0] rdata1,
	output logic [`DATA_W-1:0] rdata2
);
	logic [`DATA_W-1:0] regs [0:31];

	// entry 0 is never written
	always_ff @(posedge clk) begin
		if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

	// r0 reads as zero on both ports whatever was written to it
	assert property (@(posedge clk)
		(raddr1 == 5'd0 |-> rdata1 == '0) and (raddr2 == 5'd0 |-> rdata2 == '0))
		else $error("r0 read back nonzero");

endmodule

/* loadStore.sv */
`timescale 1ns/1ns
`include "mips_defs.svh"

module loadStore (
	input pipePkg::lsKindE storeKind,
	input logic [1:0] storeAddr,
	input logic [`DATA_W-1:0] storeData,
	output logic [3:0] byteEn,
	output logic [`DATA_W-1:0] storeOut,
	input pipePkg::lsKindE loadKind,
	input logic [1:0] loadAddr,
	input logic [`DATA_W-1:0] memWord,
	output logic [`DATA_W-1:0] loadOut
);
	import pipePkg::*;

	logic [15:0] half;
	logic [7:0] lane;

	// little endian, byte 0 is memWord[7:0]
	always_comb begin
		byteEn = 4'b0000;
		storeOut = storeData;
		case (storeKind)
			LS_W: byteEn = 4'b1111;
			LS_H, LS_HU: begin
				byteEn = storeAddr[1] ? 4'b1100 : 4'b0011;
				storeOut = {2{storeData[15:0]}};
			end
			LS_B, LS_BU: begin
				byteEn = 4'b0001 << storeAddr;
				storeOut = {4{storeData[7:0]}};
			end
			default: byteEn = 4'b0000;
		endcase
	end

	assign half = loadAddr[1] ? memWord[31:16] : memWord[15:0];
	assign lane = memWord[{loadAddr, 3'b000} +: 8];

	always_comb begin
		case (loadKind)
			LS_H: loadOut = {{16{half[15]}}, half};
			LS_HU: loadOut = {16'h0000, half};
			LS_B: loadOut = {{24{lane[7]}}, lane};
			LS_BU: loadOut = {24'h000000, lane};
			default: loadOut = memWord;
		endcase
	end

	// natural alignment on both the store and the load side
	always_comb begin
		if (!$isunknown({storeKind, storeAddr, loadKind, loadAddr})) begin
			assert final (!((storeKind inside {LS_H, LS_HU}) && storeAddr[0]) &&
				!(storeKind == LS_W && storeAddr != 2'b00))
				else $error("misaligned store, kind %0d addr %0d", storeKind, storeAddr);
			assert final (!((loadKind inside {LS_H, LS_HU}) && loadAddr[0]) &&
				!(loadKind == LS_W && loadAddr != 2'b00))
				else $error("misaligned load, kind %0d addr %0d", loadKind, loadAddr);
		end
	end

endmodule

/* syncRam.sv */
`timescale 1ns/1ns
`include "mips_defs.svh"

module syncRam #(
	parameter int addrBits = 10
) (
	input logic clk,
	input logic [3:0] we,
	input logic [addrBits-1:0] waddr,
	input logic [`DATA_W-1:0] wdata,
	input logic re,
	input logic [addrBits-1:0] raddr,
	output logic [`DATA_W-1:0] rdata
);
	logic [`DATA_W-1:0] mem [0:(1 << addrBits)-1];

	// one enable per byte lane
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (we[i]) begin
				mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	// output register keeps its word while re is low
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[raddr];
		end
	end

endmodule

/* mipsCore.sv */
`timescale 1ns/1ns
`include "mips_defs.svh"

module mipsCore (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic progWe,
	input logic [`IMEM_AW-1:0] progAddr,
	input logic [`DATA_W-1:0] progData,
	output logic outStrobe,
	output logic [`DATA_W-1:0] outData
);
	import isaPkg::*;
	import pipePkg::*;

	logic [`DATA_W-1:0] pcX;
	logic [`DATA_W-1:0] pcXPlus4;
	logic [`DATA_W-1:0] nextPc;
	logic [`DATA_W-1:0] branchTarget;
	fetchRegT fetchY;
	wbRegT wbZ;
	logic [`DATA_W-1:0] imemWord;
	logic [`DATA_W-1:0] dmemWord;
	instrU instr;
	ctrlT ctrl;
	logic [`DATA_W-1:0] rdata1;
	logic [`DATA_W-1:0] rdata2;
	logic [`DATA_W-1:0] rs;
	logic [`DATA_W-1:0] rt;
	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] loadWord;
	logic [`DATA_W-1:0] wbData;
	logic [`DATA_W-1:0] storeWord;
	logic [4:0] waddrY;
	logic [3:0] byteEn;
	logic [3:0] dmemWe;
	lsKindE storeKind;
	logic equal;
	logic taken;
	logic ioStore;

	// stage X, imem output lines up with fetchY one edge later
	always_ff @(posedge clk) begin
		if (rst) begin
			pcX <= `RESET_PC;
			fetchY.valid <= 1'b0;
		end else if (!stall) begin
			pcX <= nextPc;
			fetchY.valid <= 1'b1;
			fetchY.pc <= pcX;
			fetchY.pcPlus4 <= pcXPlus4;
		end
	end

	assign pcXPlus4 = pcX + 32'd4;

	syncRam #(.addrBits(`IMEM_AW)) imem (
		.clk(clk),
		.we({4{progWe}}),
		.waddr(progAddr),
		.wdata(progData),
		.re(!stall),
		.raddr(pcX[`IMEM_AW+1:2]),
		.rdata(imemWord)
	);

	// stage Y
	assign instr = fetchY.valid ? imemWord : '0;

	controlUnit cu (
		.instr(instr),
		.ctrl(ctrl)
	);

	regFile rf (
		.clk(clk),
		.we(wbZ.regWrite && !stall),
		.raddr1(instr.r.rs),
		.raddr2(instr.r.rt),
		.waddr(wbZ.waddr),
		.wdata(wbData),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	// bypass from writeback, r0 excluded
	assign rs = (wbZ.regWrite && wbZ.waddr != 5'd0 && wbZ.waddr == instr.r.rs) ?
		wbData : rdata1;
	assign rt = (wbZ.regWrite && wbZ.waddr != 5'd0 && wbZ.waddr == instr.r.rt) ?
		wbData : rdata2;

	assign opA = ctrl.aluRegSel ? rt : rs;

	always_comb begin
		case (ctrl.srcB)
			SRC_RT: opB = rt;
			SRC_RS: opB = rs;
			SRC_SEXT: opB = {{16{instr.i.imm16[15]}}, instr.i.imm16};
			SRC_ZEXT: opB = {16'h0000, instr.i.imm16};
			SRC_SHAMT: opB = {27'd0, instr.r.shamt};
			default: opB = '0;
		endcase
	end

	alu u_alu (
		.a(opA),
		.b(opB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.equal(equal)
	);

	// targets are relative to the delay slot address
	assign branchTarget = fetchY.pcPlus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign taken = (instr.i.op == OP_BNE) ? !equal : equal;

	always_comb begin
		case (ctrl.jumpKind)
			JMP_BRANCH: nextPc = taken ? branchTarget : pcXPlus4;
			JMP_JUMP: nextPc = {fetchY.pcPlus4[31:28], instr.j.target26, 2'b00};
			JMP_REG: nextPc = rs;
			default: nextPc = pcXPlus4;
		endcase
	end

	// jalr names its own link register, jal always uses r31
	always_comb begin
		if (ctrl.regDest) begin
			waddrY = instr.r.rd;
		end else if (ctrl.link) begin
			waddrY = 5'd31;
		end else begin
			waddrY = instr.r.rt;
		end
	end

	assign storeKind = ctrl.isStore ? ctrl.lsKind : LS_NONE;

	loadStore ls (
		.storeKind(storeKind),
		.storeAddr(aluResult[1:0]),
		.storeData(rt),
		.byteEn(byteEn),
		.storeOut(storeWord),
		.loadKind(wbZ.lsKind),
		.loadAddr(wbZ.aluOut[1:0]),
		.memWord(dmemWord),
		.loadOut(loadWord)
	);

	assign ioStore = ctrl.isStore && (aluResult[31:28] == `IO_NIBBLE);
	assign dmemWe = (stall || ioStore) ? 4'b0000 : byteEn;

	// read completes at the Y to Z edge
	syncRam #(.addrBits(`DMEM_AW)) dmem (
		.clk(clk),
		.we(dmemWe),
		.waddr(aluResult[`DMEM_AW+1:2]),
		.wdata(storeWord),
		.re(!stall),
		.raddr(aluResult[`DMEM_AW+1:2]),
		.rdata(dmemWord)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			wbZ.regWrite <= 1'b0;
			wbZ.memToReg <= 1'b0;
			wbZ.link <= 1'b0;
			wbZ.lsKind <= LS_NONE;
		end else if (!stall) begin
			wbZ.regWrite <= ctrl.regWrite;
			wbZ.memToReg <= ctrl.memToReg;
			wbZ.link <= ctrl.link;
			wbZ.lsKind <= ctrl.lsKind;
			wbZ.waddr <= waddrY;
			wbZ.aluOut <= aluResult;
			wbZ.pcPlus8 <= fetchY.pc + 32'd8;
		end
	end

	// stage Z
	assign wbData = wbZ.link ? wbZ.pcPlus8 : (wbZ.memToReg ? loadWord : wbZ.aluOut);

	// output port, a single pulse per I/O store
	always_ff @(posedge clk) begin
		if (rst) begin
			outStrobe <= 1'b0;
		end else begin
			outStrobe <= ioStore && !stall;
		end
	end

	always_ff @(posedge clk) begin
		if (ioStore && !stall) begin
			outData <= rt;
		end
	end

	// frozen cycles write no memory and produce no pulse on the next cycle
	assert property (@(posedge clk) disable iff (rst)
		stall |-> (dmemWe == 4'b0000) ##1 !outStrobe)
		else $error("memory write or output pulse during stall");

endmodule

/* mipsTb.sv */
`timescale 1ns/1ns
`include "mips_defs.svh"

module mipsTb;
	// one expected output word and the test it belongs to
	typedef struct packed {
		logic [8*12-1:0] name;
		logic [`DATA_W-1:0] value;
	} expectT;

	logic clk;
	logic rst;
	logic stall;
	logic progWe;
	logic [`IMEM_AW-1:0] progAddr;
	logic [`DATA_W-1:0] progData;
	logic outStrobe;
	logic [`DATA_W-1:0] outData;

	logic [`DATA_W-1:0] progQ[$];
	expectT expQ[$];
	int limitCycles;
	bit loaded;
	int errors;
	int checks;
	int tests;
	int testChecks;
	int testErrors;

	mipsCore DUT (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.outStrobe(outStrobe),
		.outData(outData)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic bit readTestData();
		int fd;
		int n;
		logic [8*8-1:0] tag;
		logic [8*12-1:0] testName;
		logic [8*100-1:0] skipped;
		logic [`DATA_W-1:0] w0;
		logic [`DATA_W-1:0] w1;
		logic [`DATA_W-1:0] w2;
		logic [`DATA_W-1:0] w3;
		expectT e;
		fd = $fopen("mips_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open mips_testdata.txt");
			return 1'b0;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tag);
			if (n != 1) begin
				break;
			end
			if (tag == "#") begin
				n = $fgets(skipped, fd);
			end else if (tag == "P") begin
				n = $fscanf(fd, "%h %h %h %h", w0, w1, w2, w3);
				if (n != 4) begin
					$display("program line in test data holds fewer than four words");
					$fclose(fd);
					return 1'b0;
				end
				progQ.push_back(w0);
				progQ.push_back(w1);
				progQ.push_back(w2);
				progQ.push_back(w3);
			end else if (tag == "E") begin
				n = $fscanf(fd, "%s %h", testName, w0);
				if (n != 2) begin
					$display("expected line in test data is incomplete");
					$fclose(fd);
					return 1'b0;
				end
				e.name = testName;
				e.value = w0;
				expQ.push_back(e);
			end else begin
				$display("unknown line tag %0s in test data", tag);
				$fclose(fd);
				return 1'b0;
			end
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	// one word per cycle through the imem write port
	task automatic loadProgram();
		for (int i = 0; i < progQ.size(); i++) begin
			@(posedge clk);
			#1;
			progWe = 1'b1;
			progAddr = i[`IMEM_AW-1:0];
			progData = progQ[i];
		end
		@(posedge clk);
		#1;
		progWe = 1'b0;
	endtask

	task automatic checkOutput();
		expectT e;
		if (expQ.size() == 0) begin
			$display("%0t: output strobe with no expected value left, outData %h",
				$time, outData);
			errors++;
			return;
		end
		e = expQ.pop_front();
		checks++;
		testChecks++;
		assert (outData === e.value) else begin
			$display("Fail %0t outData expected %h actual %h", $time, e.value, outData);
			errors++;
			testErrors++;
		end
		// last value of a test closes it
		if (expQ.size() == 0 || expQ[0].name != e.name) begin
			$display("test %0s: %0d checks, %0d errors", e.name, testChecks, testErrors);
			tests++;
			testChecks = 0;
			testErrors = 0;
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!rst && outStrobe) begin
			checkOutput();
		end
	end

	initial begin
		wait (loaded);
		repeat (limitCycles) @(posedge clk);
		$display("timeout after %0d cycles, %0d expected outputs never arrived",
			limitCycles, expQ.size());
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int seedDummy;
		rst = 1'b1;
		stall = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		loaded = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		testChecks = 0;
		testErrors = 0;
		limitCycles = 0;
		seedDummy = $urandom(32'hc676);
		if (!readTestData()) begin
			$display("test data could not be read");
			$display("TEST FAILED");
			$finish;
		end else begin
			limitCycles = 4 * (progQ.size() + expQ.size()) * 20;
			loaded = 1'b1;
			// program goes in while rst is high, then 16 more reset cycles
			loadProgram();
			repeat (16) @(posedge clk);
			#1;
			rst = 1'b0;
			while (expQ.size() != 0) begin
				@(posedge clk);
				#1;
				stall = ($urandom % 4) == 0;
			end
			// extra cycles to catch a duplicate pulse
			repeat (20) begin
				@(posedge clk);
				#1;
				stall = ($urandom % 4) == 0;
			end
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

/* mips_testdata.txt */
# P  four program words in hex, stored from word address 0 upward
# E  test name, then the expected outData word in hex, in output order
P 3C1E8000 24011234 2402FFFD 00221821
P AFC30000 00222023 AFC40000 0041282A
P 0041302B AFC50000 AFC60000 00023843
P 00024102 00014A00 AFC70000 AFC80000
P AFC90000 342AF00F 304BFF0F 394C00FF
P 016C6827 01A17026 AFCA0000 AFCB0000
P AFCE0000 284FFFFE 2C30FFFF 01F08821
P AFD10000 3C12ABCD 36525678 26520001
P AFD20000 AC120100 8C130100 26730001
P AFD30000 80140100 AFD40000 80140103
P AFD40000 90140102 AFD40000 90140101
P AFD40000 84140102 AFD40000 94140100
P AFD40000 94140102 AFD40000 A0050104
P A0110105 A0010106 A0120107 8C150104
P AFD50000 A4010108 A402010A 8C150108
P AFD50000 24160000 10210002 26D60001
P 26D60100 14210003 26D60002 26D60004
P 26D60008 14220002 26D60010 26D60200
P 10220002 26D60020 26D60040 AFD60000
P 0C00005A 24170005 AFD70000 AFDF0000
P 08000053 24180007 27180100 24190174
P 0320D009 27180001 AFD80000 AFDA0000
P 08000058 00000000 02F7B821 03E00008
P 26F70001 0018C080 03400008 27180003
E alu 00001231
E alu 00001237
E alu 00000001
E alu 00000000
E alu FFFFFFFE
E alu 0FFFFFFF
E alu 00123400
E alu 0000F23F
E alu 0000FF0D
E alu FFFF1206
E alu 00000002
E forward ABCD5679
E forward ABCD567A
E memory 00000079
E memory FFFFFFAB
E memory 000000CD
E memory 00000056
E memory FFFFABCD
E memory 00005679
E memory 0000ABCD
E memory 79340201
E memory FFFD1234
E branch 0000007F
E jump 0000000B
E jump 00000138
E jump 00000023
E jump 00000158

/* list.f */
+incdir+.
isaPkg.sv
pipePkg.sv
controlUnit.sv
alu.sv
regFile.sv
loadStore.sv
syncRam.sv
mipsCore.sv
mipsTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = mipsTb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
